// ==== motion_ctrl.f ====
+incdir+bench
verilog/motion_pkg.sv
verilog/motion_regs.sv
verilog/step_tick_gen.sv
verilog/axis_velocity.sv
verilog/step_pulse_shaper.sv
verilog/motor_router.sv
verilog/motion_ctrl_top.sv
bench/motion_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: motion_ctrl

sources:
  - files:
      - verilog/motion_pkg.sv
      - verilog/motion_regs.sv
      - verilog/step_tick_gen.sv
      - verilog/axis_velocity.sv
      - verilog/step_pulse_shaper.sv
      - verilog/motor_router.sv
      - verilog/motion_ctrl_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/motion_ctrl_tb.sv

// ==== bench/motion_ctrl_tasks.svh ====
// One write on the host port, returns on the falling edge after capture
task automatic write_reg(input reg_addr_t addr, input word_t data);
    @(negedge clk);
    wr_in.wr   = 1'b1;
    wr_in.addr = addr;
    wr_in.data = data;
    @(negedge clk);
    wr_in = '0;
endtask

task automatic wait_cycles(input int unsigned n);
    repeat (n) @(negedge clk);
endtask

task automatic wait_done();
    int unsigned waited;
    waited = 0;
    while (done !== 1'b1) begin
        if (waited == WAIT_LIMIT) begin
            end_with_failure("Timeout, no done pulse after the move started");
        end
        @(negedge clk);
        waited++;
    end
endtask

task automatic set_timing();
    pre_cyc   = 1 + $urandom % 4;
    pulse_cyc = 1 + $urandom % 5;
    post_cyc  = 1 + $urandom % 4;
    dt_cyc    = pre_cyc + pulse_cyc + post_cyc + 3 + $urandom % 6;  // Shapers idle per tick
    write_reg(REG_PRE, pre_cyc);
    write_reg(REG_PULSE, pulse_cyc);
    write_reg(REG_POST, post_cyc);
    write_reg(REG_DT, dt_cyc);
endtask

task automatic write_motor_cfg();
    cfg_word = $urandom;
    cfg_word[31:4*N_MOTORS] = '0;
    // Motors 0 to 3 take x, y, z and none
    for (int m = 0; m < 4; m++) begin
        cfg_word[4*m+1 +: 2] = 2'(m);
    end
    write_reg(REG_MOTOR_CFG, cfg_word);
    @(negedge clk);  // Router stage
    for (int m = 0; m < N_MOTORS; m++) begin
        check_equal($sformatf("motors[%0d].enable_n", m), !cfg_word[4*m],
                    motors[m].enable_n);
    end
endtask

task automatic write_velocities();
    for (int a = 0; a < N_AXES; a++) begin
        vel_set[a] = $urandom;
        write_reg(reg_addr_t'(REG_VEL_X + a), vel_set[a]);
    end
endtask

// Nonzero abort_after aborts that many cycles after busy rises
task automatic run_move(input int unsigned n, input int unsigned abort_after);
    longint exp_cnt;
    for (int m = 0; m < N_MOTORS; m++) begin
        if (motor_sel(m) != AXIS_NONE) begin
            exp_dir[m] = vel_set[motor_sel(m)][31] ^ motor_invert(m);
        end
    end
    write_reg(REG_STEPS, n);
    abort_sent     = 1'b0;
    abort_fall_cyc = 0;
    done_cnt       = 0;
    for (int m = 0; m < N_MOTORS; m++) begin
        rise_cnt[m] = 0;
    end
    write_reg(REG_COMMAND, 32'h1);
    check_equal("busy", 0, busy);
    @(negedge clk);
    check_equal("busy", 1, busy);
    if (abort_after != 0) begin
        wait_cycles(abort_after);
        abort_sent = 1'b1;
        write_reg(REG_COMMAND, 32'h2);
        @(negedge clk);
        check_equal("busy", 0, busy);
    end else begin
        wait_done();
    end
    wait_cycles(pre_cyc + pulse_cyc + post_cyc + 6);  // Drain shapers and router
    check_equal("done pulse count", (abort_after == 0) ? 1 : 0, done_cnt);
    if (abort_after == 0) begin
        for (int m = 0; m < N_MOTORS; m++) begin
            if (motor_sel(m) != AXIS_NONE) begin
                exp_cnt = expected_steps(n, vel_set[motor_sel(m)]);
                check_equal($sformatf("motors[%0d] step count", m), exp_cnt, rise_cnt[m]);
            end
        end
    end
endtask

// ==== bench/motion_ctrl_tb.sv ====
`timescale 1ns/10ps

module motion_ctrl_tb;
    import motion_pkg::*;

    localparam int WAIT_LIMIT = 100000;  // Cycles

    logic               clk = 1'b0;
    logic               rst_n;
    reg_write_t         wr_in;
    logic               busy;
    logic               done;
    motor_out_t         motors [N_MOTORS];

    // Bench copy of what was written
    word_t              cfg_word;
    logic signed [31:0] vel_set [N_AXES];
    logic               exp_dir [N_MOTORS];
    int unsigned        pre_cyc, pulse_cyc, post_cyc, dt_cyc;

    // Monitor state, falling edge
    logic               abort_sent;
    logic               busy_q;
    int unsigned        cyc;
    int unsigned        abort_fall_cyc;
    int unsigned        done_cnt;
    int unsigned        rise_cnt [N_MOTORS];
    int unsigned        high_len [N_MOTORS];
    int unsigned        dir_age [N_MOTORS];  // Cycles since dir last moved
    motor_out_t         motors_q [N_MOTORS];

    motion_ctrl_top UUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_in  (wr_in),
        .busy   (busy),
        .done   (done),
        .motors (motors)
    );

    always #10 clk = ~clk;

    task automatic end_with_failure(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic flag_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        end_with_failure($sformatf("** Error at %0t: %s expected %0d, got %0d",
                                   $time, name, expected, actual));
    endtask

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else flag_mismatch(name, expected, actual);
    endtask

    function automatic axis_sel_t motor_sel(input int m);
        return cfg_word[4*m+1 +: 2];
    endfunction

    function automatic logic motor_invert(input int m);
        return cfg_word[4*m+3];
    endfunction

    // Whole steps of n ticks at |v| / 2^32 steps per tick
    function automatic longint expected_steps(input int unsigned n,
                                              input logic signed [31:0] v);
        longint mag;
        mag = v;
        if (mag < 0) begin
            mag = -mag;
        end
        return (longint'(n) * mag) >>> 32;
    endfunction

    `include "motion_ctrl_tasks.svh"

    always @(negedge clk) begin
        cyc++;
        if (busy_q && !busy && abort_sent) begin
            abort_fall_cyc = cyc;
        end
        busy_q = busy;
        if (done) begin
            done_cnt++;
        end
        for (int m = 0; m < N_MOTORS; m++) begin
            if (motors[m].dir !== motors_q[m].dir) begin
                dir_age[m] = 0;
            end else begin
                dir_age[m]++;
            end
            if (motors[m].step && !motors_q[m].step) begin
                rise_cnt[m]++;
                high_len[m] = 0;
                assert (motor_sel(m) != AXIS_NONE) else end_with_failure(
                    $sformatf("Step rise on motor %0d, which selects no axis", m));
                assert (dir_age[m] >= pre_cyc) else end_with_failure(
                    $sformatf("motors[%0d].dir moved %0d cycles before step, setup is %0d",
                              m, dir_age[m], pre_cyc));
                assert (abort_fall_cyc == 0 || cyc - abort_fall_cyc <= pre_cyc + 2)
                    else end_with_failure($sformatf(
                        "Step rise on motor %0d came %0d cycles after the abort",
                        m, cyc - abort_fall_cyc));
            end
            if (motors[m].step) begin
                high_len[m]++;
            end else if (motors_q[m].step) begin
                check_equal($sformatf("motors[%0d].step width", m), pulse_cyc, high_len[m]);
            end
            motors_q[m] = motors[m];
        end
    end

    busy_clear_on_done: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !busy)
        else flag_mismatch("busy", 0, $sampled(busy));
    done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else flag_mismatch("done", 0, $sampled(done));
    busy_falls_with_done: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> done || abort_sent)
        else end_with_failure("busy fell without a done pulse");
    no_done_after_abort: assert property (@(posedge clk) disable iff (!rst_n)
        abort_sent |-> !done)
        else flag_mismatch("done", 0, $sampled(done));

    for (genvar m = 0; m < N_MOTORS; m++) begin : g_motor_checks
        dir_during_step: assert property (@(posedge clk) disable iff (!rst_n)
            motors[m].step |-> motors[m].dir == exp_dir[m])
            else flag_mismatch($sformatf("motors[%0d].dir", m), exp_dir[m],
                               $sampled(motors[m].dir));
        dir_steady_in_step: assert property (@(posedge clk) disable iff (!rst_n)
            motors[m].step && $past(motors[m].step) |-> $stable(motors[m].dir))
            else end_with_failure($sformatf("motors[%0d].dir changed inside a pulse", m));
    end

    initial begin
        void'($urandom(32'hea9d));
        rst_n          = 1'b0;
        wr_in          = '0;
        abort_sent     = 1'b0;
        busy_q         = 1'b0;
        cyc            = 0;
        abort_fall_cyc = 0;
        done_cnt       = 0;
        cfg_word       = '0;
        pre_cyc        = 1;
        pulse_cyc      = 1;
        post_cyc       = 1;
        dt_cyc         = 8;
        for (int a = 0; a < N_AXES; a++) begin
            vel_set[a] = '0;
        end
        for (int m = 0; m < N_MOTORS; m++) begin
            rise_cnt[m] = 0;
            high_len[m] = 0;
            dir_age[m]  = 0;
            motors_q[m] = '0;
            exp_dir[m]  = 1'b0;
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int m = 0; m < N_MOTORS; m++) begin
            check_equal($sformatf("motors[%0d].enable_n", m), 1, motors[m].enable_n);
            check_equal($sformatf("motors[%0d].step", m), 0, motors[m].step);
        end
        check_equal("busy", 0, busy);
        check_equal("done", 0, done);

        set_timing();
        repeat (3) begin
            write_motor_cfg();
            write_velocities();
            run_move(20 + $urandom % 40, 0);
        end
        write_motor_cfg();
        write_velocities();
        run_move(40, dt_cyc * 12 + $urandom % dt_cyc);
        run_move(10 + $urandom % 20, 0);  // Clean restart after abort

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== verilog/motion_ctrl_top.sv ====
`timescale 1ns/10ps

module motion_ctrl_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  motion_pkg::reg_write_t wr_in,
    output logic                   busy,
    output logic                   done,
    output motion_pkg::motor_out_t motors [motion_pkg::N_MOTORS]
);
    import motion_pkg::*;

    logic          start;
    logic          abort;
    logic          tick;
    word_t         steps;
    word_t         dt;
    pulse_timing_t timing;
    velocity_t     vel [N_AXES];
    motor_cfg_t    motor_cfg [N_MOTORS];
    axis_step_t    axis_strobe [N_AXES];  // One-cycle steps
    axis_step_t    axis_level [N_AXES];   // Shaped pulses

    motion_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_in     (wr_in),
        .start     (start),
        .abort     (abort),
        .steps     (steps),
        .dt        (dt),
        .timing    (timing),
        .vel       (vel),
        .motor_cfg (motor_cfg)
    );

    step_tick_gen u_tick_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .abort (abort),
        .steps (steps),
        .dt    (dt),
        .tick  (tick),
        .busy  (busy),
        .done  (done)
    );

    for (genvar a = 0; a < N_AXES; a++) begin : g_axis
        axis_velocity u_axis (
            .clk      (clk),
            .rst_n    (rst_n),
            .start    (start),
            .tick     (tick),
            .vel      (vel[a]),
            .step_out (axis_strobe[a])
        );

        step_pulse_shaper u_shaper (
            .clk      (clk),
            .rst_n    (rst_n),
            .step_in  (axis_strobe[a]),
            .timing   (timing),
            .step_out (axis_level[a])
        );
    end

    motor_router u_router (
        .clk       (clk),
        .rst_n     (rst_n),
        .axes      (axis_level),
        .motor_cfg (motor_cfg),
        .motors    (motors)
    );

endmodule

// ==== verilog/motor_router.sv ====
`timescale 1ns/10ps

module motor_router (
    input  logic                   clk,
    input  logic                   rst_n,
    input  motion_pkg::axis_step_t axes [motion_pkg::N_AXES],
    input  motion_pkg::motor_cfg_t motor_cfg [motion_pkg::N_MOTORS],
    output motion_pkg::motor_out_t motors [motion_pkg::N_MOTORS]
);
    import motion_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int m = 0; m < N_MOTORS; m++) begin
                motors[m] <= '{step: 1'b0, dir: 1'b0, enable_n: 1'b1};  // Drivers off
            end
        end else begin
            for (int m = 0; m < N_MOTORS; m++) begin
                motors[m].enable_n <= ~motor_cfg[m].enable;
                if (motor_cfg[m].sel == AXIS_NONE) begin
                    motors[m].step <= 1'b0;
                    motors[m].dir  <= motor_cfg[m].invert;
                end else begin
                    motors[m].step <= axes[motor_cfg[m].sel].step;
                    motors[m].dir  <= axes[motor_cfg[m].sel].dir ^ motor_cfg[m].invert;
                end
            end
        end
    end

endmodule

// ==== verilog/step_pulse_shaper.sv ====
`timescale 1ns/10ps

module step_pulse_shaper (
    input  logic                      clk,
    input  logic                      rst_n,
    input  motion_pkg::axis_step_t    step_in,
    input  motion_pkg::pulse_timing_t timing,
    output motion_pkg::axis_step_t    step_out
);
    import motion_pkg::*;

    shaper_state_t state;
    word_t         cnt;
    logic          dir_q;
    logic          last;

    // A count of 0 behaves as 1
    assign last = (cnt <= word_t'(1));

    assign step_out.step = (state == PULSE);
    assign step_out.dir  = dir_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
            dir_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // Strobes in other states are lost
                    if (step_in.step) begin
                        dir_q <= step_in.dir;
                        cnt   <= timing.pre;
                        state <= SETUP;
                    end
                end
                SETUP: begin
                    if (last) begin
                        cnt   <= timing.pulse;
                        state <= PULSE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                PULSE: begin
                    if (last) begin
                        cnt   <= timing.post;
                        state <= HOLD;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                HOLD: begin
                    if (last) begin
                        state <= IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/axis_velocity.sv ====
`timescale 1ns/10ps

module axis_velocity (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   tick,
    input  motion_pkg::velocity_t  vel,
    output motion_pkg::axis_step_t step_out
);
    import motion_pkg::*;

    localparam int W = $bits(word_t);

    word_t      phase;
    word_t      vel_mag;
    logic [W:0] phase_sum;  // Top bit is the carry

    // Magnitude of the most negative value still fits unsigned
    assign vel_mag   = vel[W-1] ? word_t'(-vel) : word_t'(vel);
    assign phase_sum = {1'b0, phase} + {1'b0, vel_mag};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase    <= '0;
            step_out <= '0;
        end else begin
            step_out.step <= 1'b0;
            if (start) begin
                phase <= '0;
            end else if (tick) begin
                phase         <= phase_sum[W-1:0];
                step_out.step <= phase_sum[W];
                step_out.dir  <= vel[W-1];
            end
        end
    end

endmodule

// ==== verilog/step_tick_gen.sv ====
`timescale 1ns/10ps

module step_tick_gen (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              abort,
    input  motion_pkg::word_t steps,
    input  motion_pkg::word_t dt,
    output logic              tick,
    output logic              busy,
    output logic              done
);
    import motion_pkg::*;

    word_t cycle_cnt;   // Cycles left until next tick
    word_t steps_left;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tick       <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
            cycle_cnt  <= '0;
            steps_left <= '0;
        end else begin
            tick <= 1'b0;
            done <= 1'b0;
            if (abort) begin
                busy <= 1'b0;  // No done on abort
            end else if (start) begin
                // First tick lands dt cycles after start
                cycle_cnt  <= dt - 1'b1;
                steps_left <= steps;
                busy       <= (steps != '0);
                done       <= (steps == '0);
            end else if (busy) begin
                if (steps_left == '0) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end else if (cycle_cnt <= word_t'(1)) begin
                    tick       <= 1'b1;
                    cycle_cnt  <= dt;
                    steps_left <= steps_left - 1'b1;
                end else begin
                    cycle_cnt <= cycle_cnt - 1'b1;
                end
            end
        end
    end

endmodule

// ==== verilog/motion_regs.sv ====
`timescale 1ns/10ps

module motion_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  motion_pkg::reg_write_t    wr_in,
    output logic                      start,
    output logic                      abort,
    output motion_pkg::word_t         steps,
    output motion_pkg::word_t         dt,
    output motion_pkg::pulse_timing_t timing,
    output motion_pkg::velocity_t     vel [motion_pkg::N_AXES],
    output motion_pkg::motor_cfg_t    motor_cfg [motion_pkg::N_MOTORS]
);
    import motion_pkg::*;

    localparam int CFG_W = $bits(motor_cfg_t);

    logic cmd_wr;

    assign cmd_wr = wr_in.wr && (wr_in.addr == REG_COMMAND);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start  <= 1'b0;
            abort  <= 1'b0;
            steps  <= '0;
            dt     <= '0;
            timing <= '0;
            for (int a = 0; a < N_AXES; a++) begin
                vel[a] <= '0;
            end
            for (int m = 0; m < N_MOTORS; m++) begin
                motor_cfg[m] <= '0;
            end
        end else begin
            // Command bits are strobes, not stored
            start <= cmd_wr && wr_in.data[CMD_START_BIT];
            abort <= cmd_wr && wr_in.data[CMD_ABORT_BIT];

            if (wr_in.wr) begin
                case (wr_in.addr)
                    REG_STEPS: steps        <= wr_in.data;
                    REG_DT:    dt           <= wr_in.data;
                    REG_PRE:   timing.pre   <= wr_in.data;
                    REG_PULSE: timing.pulse <= wr_in.data;
                    REG_POST:  timing.post  <= wr_in.data;
                    REG_MOTOR_CFG: begin
                        for (int m = 0; m < N_MOTORS; m++) begin
                            motor_cfg[m] <= motor_cfg_t'(wr_in.data[CFG_W*m +: CFG_W]);
                        end
                    end
                    REG_VEL_X: vel[0] <= velocity_t'(wr_in.data);
                    REG_VEL_Y: vel[1] <= velocity_t'(wr_in.data);
                    REG_VEL_Z: vel[2] <= velocity_t'(wr_in.data);
                    default: ;  // Unmapped, ignored
                endcase
            end
        end
    end

endmodule

// ==== verilog/motion_pkg.sv ====
package motion_pkg;

    localparam int N_AXES   = 3;
    localparam int N_MOTORS = 6;

    typedef logic [31:0]        word_t;
    typedef logic [3:0]         reg_addr_t;
    typedef logic signed [31:0] velocity_t;  // Sign is direction
    typedef logic [1:0]         axis_sel_t;

    localparam reg_addr_t REG_COMMAND   = 4'd0;
    localparam reg_addr_t REG_STEPS     = 4'd1;
    localparam reg_addr_t REG_DT        = 4'd2;  // Min 2
    localparam reg_addr_t REG_PRE       = 4'd3;
    localparam reg_addr_t REG_PULSE     = 4'd4;
    localparam reg_addr_t REG_POST      = 4'd5;
    localparam reg_addr_t REG_MOTOR_CFG = 4'd6;  // 4 bits per motor
    localparam reg_addr_t REG_VEL_X     = 4'd8;
    localparam reg_addr_t REG_VEL_Y     = 4'd9;
    localparam reg_addr_t REG_VEL_Z     = 4'd10;

    // Command register bits
    localparam int CMD_START_BIT = 0;
    localparam int CMD_ABORT_BIT = 1;

    localparam axis_sel_t AXIS_NONE = 2'd3;

    typedef struct packed {
        logic      wr;
        reg_addr_t addr;
        word_t     data;
    } reg_write_t;

    // Field order matches the register layout, enable in bit 0
    typedef struct packed {
        logic      invert;
        axis_sel_t sel;
        logic      enable;
    } motor_cfg_t;

    typedef struct packed {
        word_t pre;
        word_t pulse;
        word_t post;
    } pulse_timing_t;

    typedef struct packed {
        logic step;
        logic dir;
    } axis_step_t;

    typedef struct packed {
        logic step;
        logic dir;
        logic enable_n;
    } motor_out_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        PULSE,
        HOLD
    } shaper_state_t;

endpackage
